// ==== verilog/sdram_pkg.sv ====
// SDRAM front end definitions
`default_nettype none

package sdram_pkg;

    localparam int num_banks   = 4;
    localparam int sdram_aw    = 22;  // 16-bit word address
    localparam int data_read_w = 32;  // Two words per access
    localparam int word_w      = 16;

    // Client address widths
    localparam int main_ram_aw = 17;
    localparam int snd_aw      = 16;  // Byte address
    localparam int gfx_aw      = 20;
    localparam int main_rom_aw = 21;

    // Bank 0 region bases
    localparam logic [sdram_aw-1:0] zero_offset = 22'h00_0000;
    localparam logic [sdram_aw-1:0] vram_offset = 22'h10_0000;
    localparam logic [sdram_aw-1:0] oram_offset = 22'h20_0000;

    // Lane bits kept for the router
    localparam int lane_half = 0;  // High halfword of the pair
    localparam int lane_byte = 1;  // High byte of the word

    typedef enum logic [1:0] {
        ram_work   = 2'd0,
        ram_video  = 2'd1,
        ram_object = 2'd2
    } ram_region_e;

    // One client request after mapping
    typedef struct packed {
        logic                cs;
        logic                we;
        logic [sdram_aw-1:0] addr;
        logic [word_w-1:0]   din;
        logic [1:0]          mask;  // Active low, like dsn
        logic [1:0]          lane;
    } bank_req_t;

    // Command from one bank toward the controller
    typedef struct packed {
        logic [sdram_aw-1:0] addr;
        logic                rd;
        logic                wr;
        logic [word_w-1:0]   din;
        logic [1:0]          din_m;
    } sdram_cmd_t;

endpackage

`default_nettype wire

// ==== verilog/client_mapper.sv ====
// Client to bank request mapping
`default_nettype none

module client_mapper
    import sdram_pkg::*;
(
    input  wire                    clk,
    input  wire                    rst,

    // Main CPU work RAM and video RAM
    input  wire                    main_ram_cs,
    input  wire ram_region_e       region,
    input  wire                    main_rnw,
    input  wire [1:0]              dsn,
    input  wire [word_w-1:0]       main_dout,
    input  wire [main_ram_aw-1:0]  main_ram_addr,

    // Sound CPU
    input  wire                    snd_cs,
    input  wire [snd_aw-1:0]       snd_addr,

    // Graphics
    input  wire                    rom0_cs,
    input  wire [gfx_aw-1:0]       rom0_addr,
    input  wire                    rom0_half,

    // Main CPU program
    input  wire                    main_rom_cs,
    input  wire [main_rom_aw-1:0]  main_rom_addr,

    input  wire                    lvbl,
    input  wire                    vram_rfsh_en,

    output bank_req_t              bank_req [num_banks],
    output logic                   refresh_en
);

    logic [sdram_aw-1:0] main_offset;
    logic [1:0]          snd_lane;

    always_comb begin
        case (region)
            ram_video:  main_offset = vram_offset;
            ram_object: main_offset = oram_offset;
            default:    main_offset = zero_offset;
        endcase
    end

    // Word select and byte select of the sound byte address
    always_comb begin
        snd_lane            = '0;
        snd_lane[lane_half] = snd_addr[1];
        snd_lane[lane_byte] = snd_addr[0];
    end

    always_comb begin
        bank_req[0] = '{cs: main_ram_cs, we: ~main_rnw,
                        addr: {{(sdram_aw-main_ram_aw){1'b0}}, main_ram_addr} + main_offset,
                        din: main_dout, mask: dsn, lane: {1'b0, main_ram_addr[0]}};

        bank_req[1] = '{cs: snd_cs, we: 1'b0,
                        addr: {{(sdram_aw-snd_aw+1){1'b0}}, snd_addr[snd_aw-1:1]},
                        din: '0, mask: 2'b11, lane: snd_lane};

        // Graphics always reads a whole pair
        bank_req[2] = '{cs: rom0_cs, we: 1'b0, addr: {rom0_addr, rom0_half, 1'b0},
                        din: '0, mask: 2'b11, lane: 2'b00};

        bank_req[3] = '{cs: main_rom_cs, we: 1'b0,
                        addr: {{(sdram_aw-main_rom_aw){1'b0}}, main_rom_addr},
                        din: '0, mask: 2'b11, lane: {1'b0, main_rom_addr[0]}};
    end

    // Refresh allowed during vertical blank only
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            refresh_en <= 1'b0;
        end else begin
            refresh_en <= ~lvbl & vram_rfsh_en;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/bank_requester.sv ====
// Single bank request tracker
`default_nettype none

module bank_requester
    import sdram_pkg::*;
(
    input  wire                    clk,
    input  wire                    rst,
    input  wire bank_req_t         req,
    input  wire                    ack,
    input  wire                    rdy,
    input  wire [data_read_w-1:0]  data_read,
    output sdram_cmd_t             cmd,
    output logic                   ok,
    output logic [data_read_w-1:0] dout
);

    // Cache entry for the last pair read
    logic                   valid;
    logic [sdram_aw-1:1]    tag;
    logic [data_read_w-1:0] data;

    logic                rd;
    logic                wr;
    logic                acked;    // Waiting for rdy
    logic                wr_op;    // Access in flight is a write
    logic                wr_done;
    logic [sdram_aw-1:0] addr_q;
    logic [word_w-1:0]   din_q;
    logic [1:0]          mask_q;

    logic busy;
    logic rd_hit;
    logic wr_ok;
    logic issue;

    assign busy   = rd | wr | acked;
    assign rd_hit = req.cs & ~req.we & valid & (tag == req.addr[sdram_aw-1:1]);
    assign wr_ok  = req.cs & req.we & wr_done & (addr_q == req.addr);
    assign issue  = req.cs & ~busy & ~rd_hit & ~wr_ok;

    assign ok   = rd_hit | wr_ok;
    assign dout = data;
    assign cmd  = '{addr: addr_q, rd: rd, wr: wr, din: din_q, din_m: mask_q};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd      <= 1'b0;
            wr      <= 1'b0;
            acked   <= 1'b0;
            wr_op   <= 1'b0;
            wr_done <= 1'b0;
            valid   <= 1'b0;
        end else begin
            if (!(req.cs && req.we)) begin
                wr_done <= 1'b0;  // Write ok ends with cs
            end
            if (issue) begin
                rd      <= ~req.we;
                wr      <= req.we;
                wr_op   <= req.we;
                wr_done <= 1'b0;
            end else if ((rd || wr) && ack) begin
                rd    <= 1'b0;
                wr    <= 1'b0;
                acked <= 1'b1;
            end else if (acked && rdy) begin
                acked <= 1'b0;
                if (wr_op) begin
                    wr_done <= 1'b1;
                    valid   <= 1'b0;  // Cached pair may be stale now
                end else begin
                    valid <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            // Reads fetch the aligned pair
            addr_q <= req.we ? req.addr : {req.addr[sdram_aw-1:1], 1'b0};
            din_q  <= req.din;
            mask_q <= req.mask;
        end
        if (acked && rdy && !wr_op) begin
            data <= data_read;
            tag  <= addr_q[sdram_aw-1:1];
        end
    end

endmodule

`default_nettype wire

// ==== verilog/response_router.sv ====
// Client data lane selection
`default_nettype none

module response_router
    import sdram_pkg::*;
(
    input  wire                    clk,
    input  wire                    rst,
    input  wire bank_req_t         bank_req [num_banks],
    input  wire [num_banks-1:0]    bank_ok,
    input  wire [data_read_w-1:0]  bank_dout [num_banks],

    output logic                   main_ram_ok,
    output logic [word_w-1:0]      main_ram_data,
    output logic                   snd_ok,
    output logic [7:0]             snd_data,
    output logic                   rom0_ok,
    output logic [data_read_w-1:0] rom0_data,
    output logic                   main_rom_ok,
    output logic [word_w-1:0]      main_rom_data
);

    logic [word_w-1:0] snd_half;
    logic [7:0]        snd_byte;

    // Even word sits in the low half
    function automatic logic [word_w-1:0] pick_half(
        input logic [data_read_w-1:0] pair,
        input logic                   high
    );
        pick_half = high ? pair[data_read_w-1:word_w] : pair[word_w-1:0];
    endfunction

    assign main_ram_ok   = bank_ok[0];
    assign main_ram_data = pick_half(bank_dout[0], bank_req[0].lane[lane_half]);

    assign rom0_ok   = bank_ok[2];
    assign rom0_data = bank_dout[2];  // Full pair

    assign main_rom_ok   = bank_ok[3];
    assign main_rom_data = pick_half(bank_dout[3], bank_req[3].lane[lane_half]);

    always_comb begin
        snd_half = pick_half(bank_dout[1], bank_req[1].lane[lane_half]);
        snd_byte = bank_req[1].lane[lane_byte] ? snd_half[15:8] : snd_half[7:0];
    end

    // Sound CPU sees data one cycle late
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            snd_ok   <= 1'b0;
            snd_data <= 8'd0;
        end else begin
            snd_ok   <= bank_ok[1];
            snd_data <= snd_byte;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/game_sdram.sv ====
// Arcade SDRAM front end
`default_nettype none

module game_sdram
    import sdram_pkg::*;
(
    input  wire                    clk,
    input  wire                    rst,

    input  wire                    main_ram_cs,
    input  wire ram_region_e       region,
    input  wire                    main_rnw,
    input  wire [1:0]              dsn,
    input  wire [word_w-1:0]       main_dout,
    input  wire [main_ram_aw-1:0]  main_ram_addr,
    output logic                   main_ram_ok,
    output logic [word_w-1:0]      main_ram_data,

    input  wire                    snd_cs,
    input  wire [snd_aw-1:0]       snd_addr,
    output logic                   snd_ok,
    output logic [7:0]             snd_data,

    input  wire                    rom0_cs,
    input  wire [gfx_aw-1:0]       rom0_addr,
    input  wire                    rom0_half,
    output logic                   rom0_ok,
    output logic [data_read_w-1:0] rom0_data,

    input  wire                    main_rom_cs,
    input  wire [main_rom_aw-1:0]  main_rom_addr,
    output logic                   main_rom_ok,
    output logic [word_w-1:0]      main_rom_data,

    input  wire                    lvbl,
    input  wire                    vram_rfsh_en,
    output logic                   refresh_en,

    // Controller side
    output sdram_cmd_t             ba_cmd [num_banks],
    input  wire [num_banks-1:0]    ba_ack,
    input  wire [num_banks-1:0]    ba_rdy,
    input  wire [data_read_w-1:0]  data_read
);

    bank_req_t              bank_req [num_banks];
    logic [num_banks-1:0]   bank_ok;
    logic [data_read_w-1:0] bank_dout [num_banks];

    client_mapper u_mapper (
        .clk           (clk),
        .rst           (rst),
        .main_ram_cs   (main_ram_cs),
        .region        (region),
        .main_rnw      (main_rnw),
        .dsn           (dsn),
        .main_dout     (main_dout),
        .main_ram_addr (main_ram_addr),
        .snd_cs        (snd_cs),
        .snd_addr      (snd_addr),
        .rom0_cs       (rom0_cs),
        .rom0_addr     (rom0_addr),
        .rom0_half     (rom0_half),
        .main_rom_cs   (main_rom_cs),
        .main_rom_addr (main_rom_addr),
        .lvbl          (lvbl),
        .vram_rfsh_en  (vram_rfsh_en),
        .bank_req      (bank_req),
        .refresh_en    (refresh_en)
    );

    // One tracker per SDRAM bank
    for (genvar i = 0; i < num_banks; i++) begin : g_bank
        bank_requester u_bank (
            .clk       (clk),
            .rst       (rst),
            .req       (bank_req[i]),
            .ack       (ba_ack[i]),
            .rdy       (ba_rdy[i]),
            .data_read (data_read),
            .cmd       (ba_cmd[i]),
            .ok        (bank_ok[i]),
            .dout      (bank_dout[i])
        );
    end

    response_router u_router (
        .clk           (clk),
        .rst           (rst),
        .bank_req      (bank_req),
        .bank_ok       (bank_ok),
        .bank_dout     (bank_dout),
        .main_ram_ok   (main_ram_ok),
        .main_ram_data (main_ram_data),
        .snd_ok        (snd_ok),
        .snd_data      (snd_data),
        .rom0_ok       (rom0_ok),
        .rom0_data     (rom0_data),
        .main_rom_ok   (main_rom_ok),
        .main_rom_data (main_rom_data)
    );

endmodule

`default_nettype wire

// ==== testbench/sdram_bank_model.sv ====
// Four bank SDRAM model
`default_nettype none

module sdram_bank_model
    import sdram_pkg::*;
(
    input  wire                    clk,
    input  wire                    rst,
    input  wire sdram_cmd_t        ba_cmd [num_banks],
    output logic [num_banks-1:0]   ba_ack,
    output logic [num_banks-1:0]   ba_rdy,
    output logic [data_read_w-1:0] data_read
);

    logic [word_w-1:0] written [logic [23:0]];  // Words changed by writes
    int                state [num_banks];       // 0 idle, 1 ack wait, 2 rdy wait, 3 ready
    int                cnt [num_banks];
    sdram_cmd_t        op [num_banks];

    // Power-up contents, a function of bank and full word address
    function automatic logic [word_w-1:0] init_word(input int b, input logic [sdram_aw-1:0] a);
        return a[15:0] ^ {a[21:16], 10'd0} ^ (16'h4b1d * b[15:0]);
    endfunction

    function automatic logic [word_w-1:0] read_word(input int b, input logic [sdram_aw-1:0] a);
        logic [23:0] key;
        key = {b[1:0], a};
        if (written.exists(key)) return written[key];
        return init_word(b, a);
    endfunction

    always @(posedge clk or posedge rst) begin : serve
        int                pick;
        logic [word_w-1:0] w;
        if (rst) begin
            ba_ack    <= '0;
            ba_rdy    <= '0;
            data_read <= '0;
            for (int b = 0; b < num_banks; b++) state[b] = 0;
        end else begin
            ba_ack <= '0;
            ba_rdy <= '0;
            pick   = -1;
            for (int b = 0; b < num_banks; b++) begin
                case (state[b])
                    0: if (ba_cmd[b].rd || ba_cmd[b].wr) begin
                        op[b]    = ba_cmd[b];
                        cnt[b]   = 1 + int'($urandom % 4);
                        state[b] = 1;
                    end
                    1: begin
                        cnt[b]--;
                        if (cnt[b] == 0) begin
                            ba_ack[b] <= 1'b1;
                            cnt[b]    = 1 + int'($urandom % 6);
                            state[b]  = 2;
                        end
                    end
                    2: begin
                        cnt[b]--;
                        if (cnt[b] == 0) state[b] = 3;
                    end
                    default: if (pick < 0) pick = b;  // One bank returns per cycle
                endcase
            end
            if (pick >= 0) begin
                ba_rdy[pick] <= 1'b1;
                state[pick]  = 0;
                if (op[pick].wr) begin
                    w = read_word(pick, op[pick].addr);
                    if (!op[pick].din_m[0]) w[7:0] = op[pick].din[7:0];
                    if (!op[pick].din_m[1]) w[15:8] = op[pick].din[15:8];
                    written[{pick[1:0], op[pick].addr}] = w;
                end else begin
                    data_read <= {read_word(pick, op[pick].addr + 22'd1),
                                  read_word(pick, op[pick].addr)};
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== testbench/tb_game_sdram.sv ====
// SDRAM front end testbench
`default_nettype none

module tb_game_sdram
    import sdram_pkg::*;
();

    localparam int timeout_cycles = 300;

    logic clk;
    logic rst;
    logic main_ram_cs, main_rnw;
    ram_region_e region;
    logic [1:0] dsn;
    logic [word_w-1:0] main_dout;
    logic [main_ram_aw-1:0] main_ram_addr;
    logic main_ram_ok;
    logic [word_w-1:0] main_ram_data;
    logic snd_cs;
    logic [snd_aw-1:0] snd_addr;
    logic snd_ok;
    logic [7:0] snd_data;
    logic rom0_cs, rom0_half, rom0_ok;
    logic [gfx_aw-1:0] rom0_addr;
    logic [data_read_w-1:0] rom0_data;
    logic main_rom_cs, main_rom_ok;
    logic [main_rom_aw-1:0] main_rom_addr;
    logic [word_w-1:0] main_rom_data;
    logic lvbl, vram_rfsh_en, refresh_en;
    sdram_cmd_t ba_cmd [num_banks];
    logic [num_banks-1:0] ba_ack, ba_rdy;
    logic [data_read_w-1:0] data_read;

    int errors = 0;
    int checks = 0;
    int tests  = 0;
    int rd_count [num_banks] = '{default: 0};
    int wr_count [num_banks] = '{default: 0};
    logic [sdram_aw-1:0] last_rd_addr [num_banks];
    logic [sdram_aw-1:0] last_wr_addr [num_banks];
    logic [num_banks-1:0] prev_rd = '0;
    logic [num_banks-1:0] prev_wr = '0;
    logic [word_w-1:0] ref_mem [logic [23:0]];  // Reference copy of written words

    game_sdram dut_i (.*);

    sdram_bank_model model_i (
        .clk(clk), .rst(rst), .ba_cmd(ba_cmd), .ba_ack(ba_ack), .ba_rdy(ba_rdy),
        .data_read(data_read)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Count new strobes per bank
    always @(posedge clk) begin
        for (int b = 0; b < num_banks; b++) begin
            if (ba_cmd[b].rd && !prev_rd[b]) begin
                rd_count[b]++;
                last_rd_addr[b] = ba_cmd[b].addr;
            end
            if (ba_cmd[b].wr && !prev_wr[b]) begin
                wr_count[b]++;
                last_wr_addr[b] = ba_cmd[b].addr;
            end
            prev_rd[b] = ba_cmd[b].rd;
            prev_wr[b] = ba_cmd[b].wr;
        end
    end

    function automatic logic [word_w-1:0] ref_word(input int b, input logic [sdram_aw-1:0] a);
        logic [23:0] key;
        key = {b[1:0], a};
        if (ref_mem.exists(key)) return ref_mem[key];
        return a[15:0] ^ {a[21:16], 10'd0} ^ (16'h4b1d * b[15:0]);
    endfunction

    function automatic logic [sdram_aw-1:0] region_base(input int r);
        case (r)
            1:       return vram_offset;
            2:       return oram_offset;
            default: return 22'd0;
        endcase
    endfunction

    function automatic logic client_ok(input int c);
        case (c)
            0:       return main_ram_ok;
            1:       return snd_ok;
            2:       return rom0_ok;
            default: return main_rom_ok;
        endcase
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("Fail %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    // Samples at the falling edge, where outputs are settled
    task automatic wait_ok(input int c);
        int  n;
        bit  seen;
        n    = 0;
        seen = 0;
        while (!seen && n < timeout_cycles) begin
            @(negedge clk);
            seen = client_ok(c);
            n++;
        end
        if (!seen) begin
            $display("Timeout: client %0d never raised ok", c);
            errors++;
        end
    endtask

    task automatic main_ram_op(input bit rnw, input int r, input logic [16:0] a,
                               input logic [15:0] din, input logic [1:0] mask,
                               output logic [15:0] d);
        @(posedge clk);
        main_ram_cs   <= 1'b1;
        main_rnw      <= rnw;
        region        <= ram_region_e'(r);
        main_ram_addr <= a;
        main_dout     <= din;
        dsn           <= mask;
        wait_ok(0);
        d = main_ram_data;
        @(posedge clk);
        main_ram_cs <= 1'b0;
    endtask

    task automatic snd_read(input logic [15:0] a, output logic [7:0] d);
        @(posedge clk);
        snd_cs   <= 1'b1;
        snd_addr <= a;
        wait_ok(1);
        d = snd_data;
        @(posedge clk);
        snd_cs <= 1'b0;
    endtask

    task automatic gfx_read(input logic [19:0] a, input bit half, output logic [31:0] d);
        @(posedge clk);
        rom0_cs   <= 1'b1;
        rom0_addr <= a;
        rom0_half <= half;
        wait_ok(2);
        d = rom0_data;
        @(posedge clk);
        rom0_cs <= 1'b0;
    endtask

    task automatic rom_read(input logic [20:0] a, output logic [15:0] d);
        @(posedge clk);
        main_rom_cs   <= 1'b1;
        main_rom_addr <= a;
        wait_ok(3);
        d = main_rom_data;
        @(posedge clk);
        main_rom_cs <= 1'b0;
    endtask

    task automatic check_snd(input logic [15:0] a);
        logic [7:0]  d;
        logic [15:0] w;
        snd_read(a, d);
        w = ref_word(1, {7'd0, a[15:1]});
        check_value("sound byte", {24'd0, d}, {24'd0, a[0] ? w[15:8] : w[7:0]});
    endtask

    task automatic check_rom(input logic [20:0] a);
        logic [15:0] d;
        rom_read(a, d);
        check_value("program ROM word", {16'd0, d}, {16'd0, ref_word(3, {1'b0, a})});
    endtask

    task automatic finish_test(input string name, input int err_before);
        tests++;
        $display("%s done, %0d errors", name, errors - err_before);
    endtask

    initial begin
        int               e0;
        int               r;
        int               n0;
        logic [16:0]      a;
        logic [15:0]      din;
        logic [15:0]      d;
        logic [15:0]      w;
        logic [1:0]       m;
        logic [sdram_aw-1:0] wa;
        logic             l_prev;
        logic             v_prev;
        logic             l_new;
        logic             v_new;

        void'($urandom(32'h8190_0136));
        rst = 1'b1;
        {main_ram_cs, main_rnw, dsn, main_dout, main_ram_addr} = '0;
        region = ram_work;
        {snd_cs, snd_addr, rom0_cs, rom0_addr, rom0_half} = '0;
        {main_rom_cs, main_rom_addr, lvbl} = '0;
        vram_rfsh_en = 1'b1;  // Refresh condition true through reset
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        e0 = errors;
        @(negedge clk);
        check_value("ok outputs", {28'd0, main_ram_ok, snd_ok, rom0_ok, main_rom_ok}, 32'd0);
        for (int b = 0; b < num_banks; b++) begin
            check_value("rd and wr", {30'd0, ba_cmd[b].rd, ba_cmd[b].wr}, 32'd0);
        end
        check_value("refresh_en", {31'd0, refresh_en}, 32'd0);
        finish_test("Reset state", e0);

        e0 = errors;
        fork
            begin
                logic [16:0] ma;
                logic [15:0] md;
                int          mr;
                repeat (20) begin
                    ma = 17'($urandom);
                    mr = int'($urandom % 3);
                    main_ram_op(1'b1, mr, ma, 16'd0, 2'b11, md);
                    check_value("main RAM word", {16'd0, md},
                                {16'd0, ref_word(0, {5'd0, ma} + region_base(mr))});
                end
            end
            repeat (20) check_snd(16'($urandom));
            begin
                logic [19:0]         ga;
                logic                gh;
                logic [31:0]         gd;
                logic [sdram_aw-1:0] gw;
                repeat (20) begin
                    ga = 20'($urandom);
                    gh = 1'($urandom);
                    gfx_read(ga, gh, gd);
                    gw = {ga, gh, 1'b0};
                    check_value("graphics pair", gd, {ref_word(2, gw + 22'd1), ref_word(2, gw)});
                end
            end
            repeat (20) check_rom(21'($urandom));
        join
        finish_test("Overlapped reads", e0);

        e0 = errors;
        for (r = 0; r < 3; r++) begin
            a = 17'($urandom);
            wa = {5'd0, a} + region_base(r);
            main_ram_op(1'b1, r, a, 16'd0, 2'b11, d);
            check_value("bank 0 read address", {10'd0, last_rd_addr[0]},
                        {10'd0, wa[21:1], 1'b0});
            check_value("region word", {16'd0, d}, {16'd0, ref_word(0, wa)});
        end
        finish_test("Region offsets", e0);

        e0 = errors;
        repeat (12) begin
            a   = 17'($urandom);
            r   = int'($urandom % 3);
            din = 16'($urandom);
            m   = 2'($urandom);
            wa  = {5'd0, a} + region_base(r);
            main_ram_op(1'b1, r, a, 16'd0, 2'b11, d);  // Pair now cached
            check_value("read before write", {16'd0, d}, {16'd0, ref_word(0, wa)});
            n0  = wr_count[0];
            main_ram_op(1'b0, r, a, din, m, d);
            check_value("wr strobes", wr_count[0], n0 + 1);
            check_value("write address", {10'd0, last_wr_addr[0]}, {10'd0, wa});
            w = ref_word(0, wa);
            if (!m[0]) w[7:0] = din[7:0];
            if (!m[1]) w[15:8] = din[15:8];
            ref_mem[{2'd0, wa}] = w;
            main_ram_op(1'b1, r, a, 16'd0, 2'b11, d);
            check_value("read after write", {16'd0, d}, {16'd0, w});
        end
        finish_test("Masked writes", e0);

        e0 = errors;
        a = 17'($urandom);
        check_rom({4'd0, a});
        n0 = rd_count[3];
        check_rom({4'd0, a ^ 17'd1});
        check_value("program ROM rd strobes", rd_count[3], n0);
        d = 16'($urandom);
        check_snd(d);
        n0 = rd_count[1];
        check_snd(d ^ 16'd1);
        check_snd(d ^ 16'd2);
        check_value("sound rd strobes", rd_count[1], n0);
        finish_test("Cache hits", e0);

        e0 = errors;
        l_prev = lvbl;
        v_prev = vram_rfsh_en;
        repeat (30) begin
            l_new = 1'($urandom);
            v_new = 1'($urandom);
            @(posedge clk);
            lvbl         <= l_new;
            vram_rfsh_en <= v_new;
            @(negedge clk);
            check_value("refresh_en", {31'd0, refresh_en}, {31'd0, ~l_prev & v_prev});
            l_prev = l_new;
            v_prev = v_new;
        end
        finish_test("Refresh enable", e0);

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
verilog/sdram_pkg.sv
verilog/client_mapper.sv
verilog/bank_requester.sv
verilog/response_router.sv
verilog/game_sdram.sv
testbench/sdram_bank_model.sv
testbench/tb_game_sdram.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_game_sdram
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Test OK$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
